// ==== include/conv1x1_cfg.svh ====
// Configuration of the 1x1 convolution engine
// Array sizes, requantization shift and the APB register map
`ifndef CONV1X1_CFG_SVH
`define CONV1X1_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Array geometry
//////////////////////////////////////////////////////////////////////

// Input channels per spatial position
`define CONV_CHIN 8
// MAC lanes, one per output channel
`define CONV_CHOUT 8
// Output map width, WOUT*WOUT positions per layer
`define CONV_WOUT 4
// Fraction bits dropped by the requantizer
`define CONV_FRAC 8

//////////////////////////////////////////////////////////////////////
// APB byte addresses
//////////////////////////////////////////////////////////////////////

`define CONV_ADDR_CTRL 12'h000
`define CONV_ADDR_STATUS 12'h004
`define CONV_ADDR_WEIGHT 12'h100
`define CONV_ADDR_BIAS 12'h400

`endif

// ==== src/conv1x1_pkg.sv ====
// Shared data types of the 1x1 convolution engine
// Pixel, coefficient, accumulator and APB types
`default_nettype none

package conv1x1_pkg;

	// Pixels in and requantized results out
	typedef logic signed [15:0] pix_t;

	typedef logic signed [15:0] weight_t;

	// Room for CHIN full-scale products without overflow
	typedef logic signed [39:0] acc_t;

	// Bias is already in accumulator scale
	typedef logic signed [31:0] bias_t;

	// Layer select, one coefficient bank per layer
	typedef logic layer_t;

	localparam layer_t LAYER_A = 1'b0;
	localparam layer_t LAYER_B = 1'b1;

	// Configuration bus
	typedef logic [11:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire

// ==== src/coef_store.sv ====
// Coefficient store
// Flop array of DEPTH rows by LANES entries, one entry written per
// cycle, one whole row read combinationally
`timescale 1ns/1ps
`default_nettype none

module coef_store #(
	parameter type entry_t = logic [15:0],
	parameter int LANES = 8,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic [$clog2(DEPTH)-1:0] wr_row,
	input logic [$clog2(LANES)-1:0] wr_lane,
	input entry_t wr_data,
	input logic [$clog2(DEPTH)-1:0] rd_row,
	output entry_t rd_data [LANES]
);

	entry_t mem [DEPTH][LANES];

	// All rows clear to zero on reset
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int r = 0; r < DEPTH; r++) begin
				for (int l = 0; l < LANES; l++) begin
					mem[r][l] <= '0;
				end
			end
		end else if (wr_en) begin
			mem[wr_row][wr_lane] <= wr_data;
		end
	end

	// Full row for all lanes at once
	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			rd_data[l] = mem[rd_row][l];
		end
	end

endmodule

`default_nettype wire

// ==== src/apb_coef_if.sv ====
// APB configuration slave
// Decodes control, status, weight and bias windows; zero wait states,
// read data and error flag registered in the setup phase
`timescale 1ns/1ps
`default_nettype none
`include "conv1x1_cfg.svh"

module apb_coef_if (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input conv1x1_pkg::apb_addr_t paddr,
	input conv1x1_pkg::apb_data_t pwdata,
	output conv1x1_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	input logic done,
	input logic [$clog2(`CONV_WOUT*`CONV_WOUT+1)-1:0] pos_count,
	output logic w_wr_en,
	output logic [$clog2(2*`CONV_CHIN)-1:0] w_wr_row,
	output logic [$clog2(`CONV_CHOUT)-1:0] w_wr_lane,
	output conv1x1_pkg::weight_t w_wr_data,
	output logic b_wr_en,
	output logic b_wr_row,
	output logic [$clog2(`CONV_CHOUT)-1:0] b_wr_lane,
	output conv1x1_pkg::bias_t b_wr_data,
	input conv1x1_pkg::weight_t w_rd_data [`CONV_CHOUT],
	input conv1x1_pkg::bias_t b_rd_data [`CONV_CHOUT],
	output logic coef_rd,
	output conv1x1_pkg::layer_t layer,
	output logic start
);

	import conv1x1_pkg::*;

	localparam int CH_OUT = `CONV_CHOUT;
	localparam int W_WORDS = 2 * `CONV_CHIN * `CONV_CHOUT;
	localparam int B_WORDS = 2 * `CONV_CHOUT;
	localparam int W_IW = $clog2(W_WORDS);
	localparam int B_IW = $clog2(B_WORDS);
	localparam int W_RW = $clog2(2 * `CONV_CHIN);
	localparam int LW = $clog2(`CONV_CHOUT);

	logic setup;
	logic access;
	logic hit_ctrl;
	logic hit_status;
	logic hit_w;
	logic hit_b;
	logic mapped;
	logic [W_IW-1:0] w_idx;
	logic [B_IW-1:0] b_idx;
	apb_data_t rdata;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign pready = 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	assign hit_ctrl = paddr == `CONV_ADDR_CTRL;
	assign hit_status = paddr == `CONV_ADDR_STATUS;
	assign hit_w = (paddr[1:0] == 2'b00) && (paddr >= `CONV_ADDR_WEIGHT) &&
		(paddr < `CONV_ADDR_WEIGHT + 4 * W_WORDS);
	assign hit_b = (paddr[1:0] == 2'b00) && (paddr >= `CONV_ADDR_BIAS) &&
		(paddr < `CONV_ADDR_BIAS + 4 * B_WORDS);
	assign mapped = hit_ctrl || hit_status || hit_w || hit_b;

	// Word index inside each window
	assign w_idx = W_IW'((paddr - `CONV_ADDR_WEIGHT) >> 2);
	assign b_idx = B_IW'((paddr - `CONV_ADDR_BIAS) >> 2);

	// Index splits into row and lane
	assign w_wr_row = W_RW'(w_idx / CH_OUT);
	assign w_wr_lane = LW'(w_idx % CH_OUT);
	assign b_wr_row = layer_t'(b_idx / CH_OUT);
	assign b_wr_lane = LW'(b_idx % CH_OUT);

	// Writes land at the end of the access phase
	assign w_wr_en = access && pwrite && hit_w;
	assign b_wr_en = access && pwrite && hit_b;
	assign w_wr_data = weight_t'(pwdata[15:0]);
	assign b_wr_data = bias_t'(pwdata);
	assign start = access && pwrite && hit_ctrl;

	// Readback borrows the store read port for one cycle
	assign coef_rd = setup && !pwrite && (hit_w || hit_b);

	//////////////////////////////////////////////////////////////////////
	// Read data
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rdata = '0;
		if (hit_ctrl) begin
			rdata = apb_data_t'(layer);
		end else if (hit_status) begin
			rdata[0] = done;
			rdata[15:8] = 8'(pos_count);
		end else if (hit_w) begin
			// weights read back zero extended
			rdata = {16'b0, w_rd_data[w_wr_lane]};
		end else if (hit_b) begin
			rdata = b_rd_data[b_wr_lane];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			prdata <= '0;
			pslverr <= 1'b0;
			layer <= LAYER_A;
		end else begin
			// Valid exactly in the access phase that follows
			prdata <= (setup && !pwrite) ? rdata : '0;
			pslverr <= setup && !mapped;
			if (start) begin
				layer <= layer_t'(pwdata[0]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/mac_unit.sv ====
// One multiply-accumulate lane
// Product and channel-0 flag registered, then loaded into or added to
// the accumulator one cycle later
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
	input logic clk,
	input logic rst,
	input logic en,
	input logic first,
	input conv1x1_pkg::pix_t pix,
	input conv1x1_pkg::weight_t ker,
	output conv1x1_pkg::acc_t acc
);

	import conv1x1_pkg::*;

	logic signed [$bits(pix_t)+$bits(weight_t)-1:0] prod;
	logic en_s1;
	logic first_s1;

	// Stage 1
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			en_s1 <= 1'b0;
			first_s1 <= 1'b0;
		end else begin
			en_s1 <= en;
			first_s1 <= en && first;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			prod <= pix * ker;
		end
	end

	// Stage 2, channel 0 restarts the sum so positions can run back to back
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (en_s1) begin
			acc <= first_s1 ? acc_t'(prod) : acc + acc_t'(prod);
		end
	end

endmodule

`default_nettype wire

// ==== src/pass_sequencer.sv ====
// Pass sequencer
// Counts channels and positions, picks coefficient rows, and walks the
// last-channel mark down the MAC pipeline to the requantizer
`timescale 1ns/1ps
`default_nettype none
`include "conv1x1_cfg.svh"

module pass_sequencer (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input conv1x1_pkg::layer_t layer,
	input logic start,
	output logic [$clog2(2*`CONV_CHIN)-1:0] w_rd_row,
	output logic b_rd_row,
	output logic mac_en,
	output logic mac_first,
	output logic acc_valid,
	output logic done,
	output logic [$clog2(`CONV_WOUT*`CONV_WOUT+1)-1:0] pos_count
);

	import conv1x1_pkg::*;

	localparam int CW = $clog2(`CONV_CHIN);
	localparam int W_RW = $clog2(2 * `CONV_CHIN);
	localparam int POSITIONS = `CONV_WOUT * `CONV_WOUT;
	localparam int PW = $clog2(POSITIONS + 1);

	logic [CW-1:0] chan_cnt;
	logic accept;
	logic last_chan;
	logic last_s1;
	logic out_mark;

	// Pixels after the layer has finished are dropped
	assign accept = pix_valid && !done;
	assign last_chan = chan_cnt == CW'(`CONV_CHIN - 1);

	//////////////////////////////////////////////////////////////////////
	// Stage 0
	//////////////////////////////////////////////////////////////////////

	assign mac_en = accept;
	assign mac_first = accept && (chan_cnt == '0);

	// Row = layer*CHIN + channel
	assign w_rd_row = (layer == LAYER_B) ? W_RW'(chan_cnt) + W_RW'(`CONV_CHIN) :
		W_RW'(chan_cnt);
	assign b_rd_row = layer;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			chan_cnt <= '0;
		end else if (start) begin
			chan_cnt <= '0;
		end else if (accept) begin
			chan_cnt <= last_chan ? '0 : chan_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Last-channel mark through stages 1, 2 and output
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			last_s1 <= 1'b0;
			acc_valid <= 1'b0;
			out_mark <= 1'b0;
		end else begin
			last_s1 <= accept && last_chan;
			acc_valid <= last_s1;
			// same cycle as out_valid
			out_mark <= acc_valid;
		end
	end

	// Positions count as their result is strobed out
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pos_count <= '0;
			done <= 1'b0;
		end else if (start) begin
			pos_count <= '0;
			done <= 1'b0;
		end else begin
			if (acc_valid) begin
				pos_count <= pos_count + 1'b1;
			end
			if (out_mark && (pos_count == PW'(POSITIONS))) begin
				done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/requant_relu.sv ====
// Requantizer for all lanes
// Bias add, arithmetic shift by FRAC, ReLU and positive saturation,
// result registered with a one-cycle valid
`timescale 1ns/1ps
`default_nettype none
`include "conv1x1_cfg.svh"

module requant_relu (
	input logic clk,
	input logic rst,
	input logic strobe,
	input conv1x1_pkg::acc_t acc [`CONV_CHOUT],
	input conv1x1_pkg::bias_t bias [`CONV_CHOUT],
	output conv1x1_pkg::pix_t ofm [`CONV_CHOUT],
	output logic out_valid
);

	import conv1x1_pkg::*;

	// Largest positive output value
	localparam acc_t PIX_MAX = acc_t'(2 ** ($bits(pix_t) - 1) - 1);

	pix_t ofm_next [`CONV_CHOUT];

	always_comb begin
		acc_t scaled;
		for (int i = 0; i < `CONV_CHOUT; i++) begin
			scaled = (acc[i] + acc_t'(bias[i])) >>> `CONV_FRAC;
			if (scaled < 0) begin
				ofm_next[i] = '0;
			end else if (scaled > PIX_MAX) begin
				ofm_next[i] = pix_t'(PIX_MAX);
			end else begin
				ofm_next[i] = pix_t'(scaled);
			end
		end
	end

	// Holds between strobes
	always_ff @(posedge clk) begin
		if (strobe) begin
			ofm <= ofm_next;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= strobe;
		end
	end

endmodule

`default_nettype wire

// ==== src/conv1x1_top.sv ====
// 1x1 convolution engine, expand stage of a fire module
// Two layers share CHOUT MAC lanes; coefficients and control over APB
`timescale 1ns/1ps
`default_nettype none
`include "conv1x1_cfg.svh"

module conv1x1_top (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input conv1x1_pkg::apb_addr_t paddr,
	input conv1x1_pkg::apb_data_t pwdata,
	output conv1x1_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	input logic pix_valid,
	input conv1x1_pkg::pix_t pix,
	output logic out_valid,
	output conv1x1_pkg::pix_t ofm [`CONV_CHOUT],
	output logic layer_done
);

	import conv1x1_pkg::*;

	localparam int W_ROWS = 2 * `CONV_CHIN;
	localparam int W_RW = $clog2(W_ROWS);
	localparam int LW = $clog2(`CONV_CHOUT);
	localparam int PW = $clog2(`CONV_WOUT * `CONV_WOUT + 1);

	logic w_wr_en;
	logic [W_RW-1:0] w_wr_row;
	logic [LW-1:0] w_wr_lane;
	weight_t w_wr_data;
	logic b_wr_en;
	logic b_wr_row;
	logic [LW-1:0] b_wr_lane;
	bias_t b_wr_data;
	logic coef_rd;
	layer_t layer;
	logic start;

	logic [W_RW-1:0] seq_w_rd_row;
	logic seq_b_rd_row;
	logic [W_RW-1:0] w_rd_row;
	logic b_rd_row;
	weight_t w_rd_data [`CONV_CHOUT];
	bias_t b_rd_data [`CONV_CHOUT];

	logic mac_en;
	logic mac_first;
	logic acc_valid;
	logic [PW-1:0] pos_count;
	acc_t acc [`CONV_CHOUT];

	apb_coef_if u_apb (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.done(layer_done),
		.pos_count(pos_count),
		.w_wr_en(w_wr_en),
		.w_wr_row(w_wr_row),
		.w_wr_lane(w_wr_lane),
		.w_wr_data(w_wr_data),
		.b_wr_en(b_wr_en),
		.b_wr_row(b_wr_row),
		.b_wr_lane(b_wr_lane),
		.b_wr_data(b_wr_data),
		.w_rd_data(w_rd_data),
		.b_rd_data(b_rd_data),
		.coef_rd(coef_rd),
		.layer(layer),
		.start(start)
	);

	// APB readback takes the row port only when the datapath leaves it idle
	assign w_rd_row = (coef_rd && !mac_en) ? w_wr_row : seq_w_rd_row;
	assign b_rd_row = (coef_rd && !acc_valid) ? b_wr_row : seq_b_rd_row;

	coef_store #(
		.entry_t(weight_t),
		.LANES(`CONV_CHOUT),
		.DEPTH(W_ROWS)
	) u_wstore (
		.clk(clk),
		.rst(rst),
		.wr_en(w_wr_en),
		.wr_row(w_wr_row),
		.wr_lane(w_wr_lane),
		.wr_data(w_wr_data),
		.rd_row(w_rd_row),
		.rd_data(w_rd_data)
	);

	coef_store #(
		.entry_t(bias_t),
		.LANES(`CONV_CHOUT),
		.DEPTH(2)
	) u_bstore (
		.clk(clk),
		.rst(rst),
		.wr_en(b_wr_en),
		.wr_row(b_wr_row),
		.wr_lane(b_wr_lane),
		.wr_data(b_wr_data),
		.rd_row(b_rd_row),
		.rd_data(b_rd_data)
	);

	pass_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.layer(layer),
		.start(start),
		.w_rd_row(seq_w_rd_row),
		.b_rd_row(seq_b_rd_row),
		.mac_en(mac_en),
		.mac_first(mac_first),
		.acc_valid(acc_valid),
		.done(layer_done),
		.pos_count(pos_count)
	);

	//////////////////////////////////////////////////////////////////////
	// MAC lanes, one per output channel
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `CONV_CHOUT; i++) begin : g_lane
		mac_unit u_mac (
			.clk(clk),
			.rst(rst),
			.en(mac_en),
			.first(mac_first),
			.pix(pix),
			.ker(w_rd_data[i]),
			.acc(acc[i])
		);
	end

	requant_relu u_rq (
		.clk(clk),
		.rst(rst),
		.strobe(acc_valid),
		.acc(acc),
		.bias(b_rd_data),
		.ofm(ofm),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

// ==== tests/conv1x1_assertions.sv ====
// Protocol and timing checks for the 1x1 convolution top level
// Output pulse width, APB error timing, layer_done clearing
`timescale 1ns/1ps
`default_nettype none
`include "conv1x1_cfg.svh"

module conv1x1_assertions (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input conv1x1_pkg::apb_addr_t paddr,
	input logic pslverr,
	input logic out_valid,
	input logic layer_done
);

	import conv1x1_pkg::*;

	logic ctrl_wr;
	int fail_count = 0;

	assign ctrl_wr = psel && penable && pwrite && (paddr == `CONV_ADDR_CTRL);

	// One result per pulse
	single_pulse: assert property (@(posedge clk) disable iff (!rst)
		out_valid |=> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high for two cycles in a row");
	end

	// Error flag only in the access phase
	err_in_access: assert property (@(posedge clk) disable iff (!rst)
		pslverr |-> psel && penable)
	else begin
		fail_count++;
		$error("pslverr high outside an APB access phase");
	end

	done_sticky: assert property (@(posedge clk) disable iff (!rst)
		$past(layer_done) && !layer_done |-> $past(ctrl_wr))
	else begin
		fail_count++;
		$error("layer_done fell without a CTRL write");
	end

endmodule

`default_nettype wire

// ==== tests/conv1x1_tb.sv ====
// Testbench for the 1x1 convolution engine
// Random coefficients and pixels checked against a reference model,
// APB readback, back-to-back timing, layer end and layer switching
`timescale 1ns/1ps
`default_nettype none
`include "conv1x1_cfg.svh"

module conv1x1_tb;

	import conv1x1_pkg::*;

	localparam int CHIN = `CONV_CHIN;
	localparam int CHOUT = `CONV_CHOUT;
	localparam int POSITIONS = `CONV_WOUT * `CONV_WOUT;
	localparam int APB_TIMEOUT = 16;
	localparam int DRAIN_TIMEOUT = 200;
	localparam int DONE_TIMEOUT = 200;
	localparam int QUIET_CYCLES = 40;
	localparam longint PIX_MAX = 32767;
	localparam apb_data_t STATUS_DONE = apb_data_t'((POSITIONS << 8) | 1);

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic pix_valid;
	pix_t pix;
	logic out_valid;
	pix_t ofm [CHOUT];
	logic layer_done;

	// Reference copy of both coefficient banks
	weight_t wmod [2][CHIN][CHOUT];
	bias_t bmod [2][CHOUT];
	layer_t cur_layer;
	pix_t pos_pix [CHIN];

	// Expected results, CHOUT entries per position, and their due cycles
	pix_t exp_q [$];
	int due_q [$];
	int cyc;
	int mon_chan;
	int mon_pos;
	int out_cnt;
	logic exp_done;
	int zero_hits;
	int sat_hits;

	conv1x1_top dut0 (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.pix_valid(pix_valid),
		.pix(pix),
		.out_valid(out_valid),
		.ofm(ofm),
		.layer_done(layer_done)
	);

	bind conv1x1_top conv1x1_assertions u_chk (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pslverr(pslverr),
		.out_valid(out_valid),
		.layer_done(layer_done)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compares
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		abort_run();
	endtask

	task automatic check_pix(input string name, input pix_t got, input pix_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Random values and reference model
	//////////////////////////////////////////////////////////////////////

	// Mostly small values, now and then full range to reach saturation
	function automatic weight_t rand_weight();
		if ($urandom_range(7) == 0) begin
			return weight_t'($urandom);
		end
		return weight_t'(int'($urandom_range(2047)) - 1024);
	endfunction

	function automatic pix_t rand_pix();
		if ($urandom_range(7) == 0) begin
			return pix_t'($urandom);
		end
		return pix_t'(int'($urandom_range(4095)) - 2048);
	endfunction

	function automatic bias_t rand_bias();
		return bias_t'(int'($urandom_range(2097151)) - 1048576);
	endfunction

	// Sum of products plus bias, shift, then clamp to 0..32767
	function automatic pix_t model_lane(input layer_t l, input int o);
		longint sum;
		sum = longint'(bmod[l][o]);
		for (int c = 0; c < CHIN; c++) begin
			sum += longint'(pos_pix[c]) * longint'(wmod[l][c][o]);
		end
		sum = sum >>> `CONV_FRAC;
		if (sum < 0) begin
			zero_hits++;
			return '0;
		end
		if (sum > PIX_MAX) begin
			sat_hits++;
			return pix_t'(PIX_MAX);
		end
		return pix_t'(sum);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// APB master
	//////////////////////////////////////////////////////////////////////

	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waited;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!pready) begin
			if (waited >= APB_TIMEOUT) begin
				fail_timeout("pready");
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		if (waited != 0) begin
			$display("APB transfer to %h took %0d wait states", addr, waited);
			abort_run();
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_bit($sformatf("pslverr@%h", addr), err, 1'b0);
	endtask

	task automatic apb_read_check(input apb_addr_t addr, input apb_data_t exp,
			input logic exp_err);
		apb_data_t rd;
		logic err;
		apb_xfer(1'b0, addr, '0, rd, err);
		check_bit($sformatf("pslverr@%h", addr), err, exp_err);
		check_word($sformatf("prdata@%h", addr), rd, exp);
	endtask

	task automatic load_coefs();
		int idx;
		for (int l = 0; l < 2; l++) begin
			for (int c = 0; c < CHIN; c++) begin
				for (int o = 0; o < CHOUT; o++) begin
					wmod[l][c][o] = rand_weight();
					idx = (l * CHIN + c) * CHOUT + o;
					apb_write(`CONV_ADDR_WEIGHT + apb_addr_t'(4 * idx),
						apb_data_t'(wmod[l][c][o]));
				end
			end
			for (int o = 0; o < CHOUT; o++) begin
				bmod[l][o] = rand_bias();
				apb_write(`CONV_ADDR_BIAS + apb_addr_t'(4 * (l * CHOUT + o)),
					apb_data_t'(bmod[l][o]));
			end
		end
	endtask

	task automatic readback_sample();
		int l;
		int c;
		int o;
		int idx;
		for (int i = 0; i < 24; i++) begin
			l = int'($urandom_range(1));
			c = int'($urandom_range(CHIN - 1));
			o = int'($urandom_range(CHOUT - 1));
			idx = (l * CHIN + c) * CHOUT + o;
			// Weights come back zero extended
			apb_read_check(`CONV_ADDR_WEIGHT + apb_addr_t'(4 * idx),
				{16'b0, wmod[l][c][o]}, 1'b0);
		end
		for (int i = 0; i < 6; i++) begin
			l = int'($urandom_range(1));
			o = int'($urandom_range(CHOUT - 1));
			apb_read_check(`CONV_ADDR_BIAS + apb_addr_t'(4 * (l * CHOUT + o)),
				apb_data_t'(bmod[l][o]), 1'b0);
		end
		// Holes in the map, one of them unaligned
		apb_read_check(12'h008, '0, 1'b1);
		apb_read_check(`CONV_ADDR_WEIGHT + 12'h002, '0, 1'b1);
		apb_read_check(12'hFFC, '0, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Pixel stream
	//////////////////////////////////////////////////////////////////////

	task automatic drive_pixel(input pix_t p, input int gap);
		for (int g = 0; g < gap; g++) begin
			@(posedge clk);
			pix_valid <= 1'b0;
		end
		@(posedge clk);
		pix_valid <= 1'b1;
		pix <= p;
	endtask

	task automatic stream_end();
		@(posedge clk);
		pix_valid <= 1'b0;
	endtask

	task automatic drive_position(input int max_gap, input logic full_scale);
		for (int c = 0; c < CHIN; c++) begin
			pos_pix[c] = full_scale ? pix_t'(PIX_MAX) : rand_pix();
			drive_pixel(pos_pix[c], int'($urandom_range(max_gap)));
		end
		// Last channel is on the bus, result is now known
		for (int o = 0; o < CHOUT; o++) begin
			exp_q.push_back(model_lane(cur_layer, o));
		end
	endtask

	task automatic wait_outputs();
		int waited;
		waited = 0;
		@(posedge clk);
		while (exp_q.size() != 0 || due_q.size() != 0) begin
			if (waited >= DRAIN_TIMEOUT) begin
				fail_timeout("expected outputs");
			end else begin
				waited++;
				@(posedge clk);
			end
		end
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!layer_done) begin
			if (waited >= DONE_TIMEOUT) begin
				fail_timeout("layer_done");
			end else begin
				waited++;
				@(negedge clk);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic due_now;
		if (rst) begin
			due_now = (due_q.size() != 0) && (due_q[0] == cyc);
			check_bit("out_valid", out_valid, due_now);
			check_bit("layer_done", layer_done, exp_done);
			if (due_now) begin
				void'(due_q.pop_front());
				for (int o = 0; o < CHOUT; o++) begin
					check_pix($sformatf("ofm[%0d]", o), ofm[o], exp_q.pop_front());
				end
				out_cnt++;
				if (out_cnt == POSITIONS) begin
					exp_done = 1'b1;
				end
			end
			// Result due 3 cycles after the last channel of a position
			if (pix_valid && mon_pos < POSITIONS) begin
				if (mon_chan == CHIN - 1) begin
					due_q.push_back(cyc + 3);
					mon_chan = 0;
					mon_pos++;
				end else begin
					mon_chan++;
				end
			end
			// CTRL write restarts the layer at the next edge
			if (psel && penable && pwrite && paddr == `CONV_ADDR_CTRL) begin
				mon_chan = 0;
				mon_pos = 0;
				out_cnt = 0;
				exp_done = 1'b0;
			end
			cyc++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(57));
		rst = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pix_valid = 1'b0;
		pix = '0;
		cur_layer = LAYER_A;
		cyc = 0;
		mon_chan = 0;
		mon_pos = 0;
		out_cnt = 0;
		exp_done = 1'b0;
		zero_hits = 0;
		sat_hits = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;

		load_coefs();
		apb_read_check(`CONV_ADDR_CTRL, '0, 1'b0);
		apb_read_check(`CONV_ADDR_STATUS, '0, 1'b0);
		readback_sample();

		// Layer A, first half with gaps
		for (int p = 0; p < POSITIONS / 2; p++) begin
			drive_position(3, 1'b0);
		end
		stream_end();
		wait_outputs();

		// Second half back to back, led by a full-scale position
		drive_position(0, 1'b1);
		for (int p = 1; p < POSITIONS / 2; p++) begin
			drive_position(0, 1'b0);
		end
		stream_end();
		wait_outputs();
		wait_done();
		apb_read_check(`CONV_ADDR_STATUS, STATUS_DONE, 1'b0);

		// Pixels after the layer end must be dropped
		for (int i = 0; i < 2 * CHIN; i++) begin
			drive_pixel(rand_pix(), 0);
		end
		stream_end();
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(posedge clk);
		end
		apb_read_check(`CONV_ADDR_STATUS, STATUS_DONE, 1'b0);

		// Layer B on the second bank
		cur_layer = LAYER_B;
		apb_write(`CONV_ADDR_CTRL, 32'h1);
		apb_read_check(`CONV_ADDR_CTRL, 32'h1, 1'b0);
		apb_read_check(`CONV_ADDR_STATUS, '0, 1'b0);
		drive_position(0, 1'b1);
		for (int p = 1; p < POSITIONS; p++) begin
			drive_position((p % 2 == 0) ? 2 : 0, 1'b0);
		end
		stream_end();
		wait_outputs();
		wait_done();
		apb_read_check(`CONV_ADDR_STATUS, STATUS_DONE, 1'b0);

		if (zero_hits == 0 || sat_hits == 0) begin
			$display("Stimulus never reached ReLU zero (%0d) or saturation (%0d)",
				zero_hits, sat_hits);
			abort_run();
		end
		if (dut0.u_chk.fail_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", dut0.u_chk.fail_count);
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
src/conv1x1_pkg.sv
src/coef_store.sv
src/apb_coef_if.sv
src/mac_unit.sv
src/pass_sequencer.sv
src/requant_relu.sv
src/conv1x1_top.sv
tests/conv1x1_assertions.sv
tests/conv1x1_tb.sv

// ==== Makefile ====
SRCS := $(filter %.sv,$(shell cat files.f)) $(wildcard include/*.svh)

all: run

obj_dir/Vconv1x1_tb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module conv1x1_tb -o Vconv1x1_tb

run: obj_dir/Vconv1x1_tb
	./obj_dir/Vconv1x1_tb > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
